// File: lfb_ddr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lfb_ddr_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              ln_done,
    input  logic [lfb_video_pkg::VW-1:0]      vrender,
    input  logic [lfb_video_pkg::VW-1:0]      ln_v,
    input  logic                              frame,
    // line RAM
    output logic [lfb_video_pkg::HW-1:0]      fb_addr,
    input  logic [lfb_video_pkg::PXL_W-1:0]   fb_din,
    output logic                              fb_clr,
    output logic                              fb_done,
    output logic                              line,
    // screen buffer
    output logic [lfb_video_pkg::HW-1:0]      rd_addr,
    output logic                              scr_we,
    // blank timer
    input  logic [lfb_video_pkg::HW-1:0]      hcnt,
    input  logic [lfb_video_pkg::HW-1:0]      hlim,
    input  logic                              blank_start,
    input  logic                              active,
    // external memory
    input  logic                              mem_busy,
    output logic [7:0]                        mem_burstcnt,
    output logic [lfb_mem_pkg::MEM_AW-1:0]    mem_addr,
    output logic [lfb_mem_pkg::MEM_DW-1:0]    mem_din,
    output logic [7:0]                        mem_be,
    input  logic                              mem_dout_ready,
    output logic                              mem_rd,
    output logic                              mem_we,
    // status
    input  logic [7:0]                        st_addr,
    output logic [7:0]                        st_dout
);

    import lfb_video_pkg::*;
    import lfb_mem_pkg::*;

    localparam logic [1:0] IDLE  = 2'd0;
    localparam logic [1:0] READ  = 2'd1;
    localparam logic [1:0] WRITE = 2'd2;

    localparam int PAD_W = MEM_AW - $bits(MEM_BASE) - AW;

    logic [1:0]    st;
    logic          ln_done_l;
    logic          do_wr;               // rendered line waiting for flush
    logic          rd_pend;             // blank seen, readback still owed
    logic [VW:0]   act_row;             // frame bit and line of the transfer
    logic [HW-1:0] col;
    logic [HW-1:0] nx_rd_addr;
    logic          ln_rise;
    logic          fb_over;
    logic          wr_ok;

    assign ln_rise    = ln_done & ~ln_done_l;
    assign fb_over    = &fb_addr;
    assign nx_rd_addr = rd_addr + 1'd1;
    // flush only when it can end before the next blank
    assign wr_ok      = (do_wr | ln_rise) & ~fb_clr & active & (hcnt < hlim);

    assign col          = (st == WRITE) ? fb_addr : rd_addr;
    assign mem_addr     = {MEM_BASE, {PAD_W{1'b0}}, act_row, col};
    assign mem_din      = {{(MEM_DW - PXL_W){1'b0}}, fb_din};
    assign mem_be       = MEM_BE;
    assign mem_burstcnt = (st == WRITE) ? 8'd1 : BURST_LEN;   // writes go word by word

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= IDLE;
            ln_done_l <= 1'b0;
            do_wr     <= 1'b0;
            rd_pend   <= 1'b0;
            act_row   <= '0;
            fb_addr   <= '0;
            fb_clr    <= 1'b0;
            fb_done   <= 1'b0;
            line      <= 1'b0;
            rd_addr   <= '0;
            scr_we    <= 1'b0;
            mem_rd    <= 1'b0;
            mem_we    <= 1'b0;
        end else begin
            fb_done   <= 1'b0;
            ln_done_l <= ln_done;
            if (ln_rise) do_wr <= 1'b1;
            if (blank_start) rd_pend <= 1'b1;
            // background clear, independent of the FSM
            if (fb_clr) begin
                fb_addr <= fb_addr + 1'd1;
                if (fb_over) fb_clr <= 1'b0;
            end
            case (st)
                IDLE: begin
                    if (blank_start || rd_pend) begin      // readback wins
                        act_row <= {~frame, ln_v};
                        rd_addr <= '0;
                        mem_rd  <= 1'b1;
                        scr_we  <= 1'b1;
                        rd_pend <= 1'b0;
                        st      <= READ;
                    end else if (wr_ok) begin
                        act_row <= {frame, vrender};
                        fb_addr <= '0;
                        mem_we  <= 1'b1;
                        do_wr   <= 1'b0;
                        st      <= WRITE;
                    end
                end
                READ: begin
                    if (!mem_busy) mem_rd <= 1'b0;      // request taken
                    if (mem_dout_ready) begin
                        rd_addr <= nx_rd_addr;
                        if (&rd_addr) begin
                            scr_we <= 1'b0;
                            st     <= IDLE;
                        end else if (&rd_addr[BURST_AW-1:0]) begin
                            mem_rd <= 1'b1;             // next burst at nx_rd_addr
                        end
                    end
                end
                WRITE: begin
                    if (!mem_busy) begin
                        fb_addr <= fb_addr + 1'd1;
                        if (fb_over) begin
                            mem_we  <= 1'b0;
                            line    <= ~line;
                            fb_done <= 1'b1;
                            fb_clr  <= 1'b1;
                            st      <= IDLE;
                        end
                    end
                end
                default: st <= IDLE;
            endcase
        end
    end

    // status read port, group in the top three address bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st_dout <= '0;
        end else begin
            case (st_addr[7:5])
                3'd0: st_dout <= {2'd0, mem_we, mem_rd, 2'd0, st};
                3'd1: st_dout <= {3'd0, frame, 1'd0, mem_dout_ready, mem_busy, line};
                3'd2: st_dout <= st_addr[0] ? fb_din[15:8] : fb_din[7:0];
                3'd3: st_dout <= {fb_clr, fb_done, scr_we, rd_pend, do_wr, 3'd0};
                default: st_dout <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: lfb_hblank_timer.sv
`timescale 1ns/1ps
`default_nettype none

module lfb_hblank_timer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pxl_cen,
    input  logic                          lhbl,         // low during blank
    output logic [lfb_video_pkg::HW-1:0]  hcnt,
    output logic [lfb_video_pkg::HW-1:0]  hlim,
    output logic                          blank_start,
    output logic                          active
);

    import lfb_video_pkg::*;

    logic          lhbl_l;
    logic [HW-1:0] hblen;               // measured blank length in pixels
    logic          blank_fall;
    logic          blank_rise;
    logic          hmax;

    assign blank_fall  = lhbl_l & ~lhbl;
    assign blank_rise  = ~lhbl_l & lhbl;
    assign hmax        = &hcnt;
    assign blank_start = pxl_cen & blank_fall;
    assign active      = lhbl_l;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt   <= '0;
            hlim   <= '0;
            hblen  <= '0;
            lhbl_l <= 1'b0;
        end else if (pxl_cen) begin
            lhbl_l <= lhbl;
            // saturate, a line longer than 512 pixels must not wrap
            if (!hmax) begin
                hcnt <= hcnt + 1'd1;
            end
            if (blank_fall) begin
                hcnt <= '0;
                // latest start so the flush is over before the next blank
                // no flush until one full blank was measured
                hlim <= (hblen == '0) ? '0 : hcnt - hblen;
            end
            if (blank_rise) begin
                hblen <= hcnt;                  // count since blank start
            end
        end
    end

endmodule

`default_nettype wire

// File: lfb_line_ram.sv
`timescale 1ns/1ps
`default_nettype none

module lfb_line_ram (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              line,
    // renderer side
    input  logic [lfb_video_pkg::HW-1:0]      ln_addr,
    input  logic [lfb_video_pkg::PXL_W-1:0]   ln_data,
    input  logic                              ln_we,
    // flush and clear side
    input  logic [lfb_video_pkg::HW-1:0]      fb_addr,
    input  logic                              fb_clr,
    output logic [lfb_video_pkg::PXL_W-1:0]   fb_din
);

    import lfb_video_pkg::*;

    logic [PXL_W-1:0] ram [2][2**HW];
    logic             clr_bank;         // bank being wiped

    // line has toggled by the time the clear starts, so the bank that was
    // just flushed is captured on the last cycle before fb_clr rises
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clr_bank <= 1'b0;
        end else if (!fb_clr) begin
            clr_bank <= line;
        end
    end

    // each bank has one writer at a time: either the clear or the renderer
    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (fb_clr && clr_bank == 1'(b)) begin
                ram[b][fb_addr] <= '0;
            end else if (ln_we && line == 1'(b)) begin
                ram[b][ln_addr] <= ln_data;
            end
        end
    end

    assign fb_din = ram[line][fb_addr];   // flush reads the freshly drawn bank

endmodule

`default_nettype wire

// File: lfb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module lfb_mem_model (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              mem_busy,
    input  logic                              mem_rd,
    input  logic                              mem_we,
    input  logic [7:0]                        mem_burstcnt,
    input  logic [lfb_mem_pkg::MEM_AW-1:0]    mem_addr,
    input  logic [lfb_mem_pkg::MEM_DW-1:0]    mem_din,
    output logic [lfb_mem_pkg::MEM_DW-1:0]    mem_dout,
    output logic                              mem_dout_ready
);

    import lfb_mem_pkg::*;

    logic [15:0]       mem [logic [MEM_AW-1:0]];   // only written words are stored
    logic [MEM_AW-1:0] rd_ptr;
    logic [8:0]        rd_left;                    // beats still owed
    logic [2:0]        rd_wait;

    // words never written read as zero
    function automatic logic [15:0] read_word(input logic [MEM_AW-1:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return 16'h0000;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr         <= '0;
            rd_left        <= '0;
            rd_wait        <= '0;
            mem_dout       <= '0;
            mem_dout_ready <= 1'b0;
        end else begin
            mem_dout_ready <= 1'b0;
            if (mem_we && !mem_busy) begin
                mem[mem_addr] = mem_din[15:0];
            end
            if (mem_rd && !mem_busy) begin
                rd_ptr  <= mem_addr;
                rd_left <= {1'b0, mem_burstcnt};
                rd_wait <= {1'b0, mem_addr[8:7]} + 3'd2;   // latency differs per burst
            end else if (rd_left != '0 && !mem_busy) begin
                if (rd_wait != '0) begin
                    rd_wait <= rd_wait - 3'd1;
                end else begin
                    // upper lanes carry junk so only the low lane may be used
                    mem_dout       <= {{3{~rd_ptr[15:0]}}, read_word(rd_ptr)};
                    mem_dout_ready <= 1'b1;
                    rd_ptr         <= rd_ptr + 1'b1;
                    rd_left        <= rd_left - 9'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: lfb_mem_pkg.sv
`default_nettype none

// external burst memory as seen by the frame buffer controller
package lfb_mem_pkg;

    localparam logic [7:0] BURST_LEN = 8'd128;      // beats per read burst
    localparam int         BURST_AW  = $clog2(BURST_LEN);

    localparam int MEM_AW = 29;         // 64-bit word address
    localparam int MEM_DW = 64;

    // frame store sits in this region of the address space
    localparam logic [3:0] MEM_BASE = 4'd3;

    // pixels live in the low 16 bits of each word
    localparam logic [7:0] MEM_BE = 8'h03;

endpackage

`default_nettype wire

// File: lfb_scan_buf.sv
`timescale 1ns/1ps
`default_nettype none

module lfb_scan_buf (
    input  logic                              clk,
    input  logic                              rst,
    // fill from memory read data
    input  logic                              scr_we,
    input  logic                              mem_dout_ready,
    input  logic [lfb_video_pkg::HW-1:0]      rd_addr,
    input  logic [lfb_video_pkg::PXL_W-1:0]   wr_data,
    // video side
    input  logic [lfb_video_pkg::HW-1:0]      hdump,
    output logic [lfb_video_pkg::PXL_W-1:0]   pxl_data
);

    import lfb_video_pkg::*;

    logic [PXL_W-1:0] buf_mem [2**HW];  // the line on screen
    logic             beat_we;

    // a beat is taken on the same edge as its ready strobe
    assign beat_we = scr_we & mem_dout_ready;

    always_ff @(posedge clk) begin
        if (beat_we) begin
            buf_mem[rd_addr] <= wr_data;
        end
    end

    // one cycle from hdump to pixel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl_data <= '0;             // black out of reset
        end else begin
            pxl_data <= buf_mem[hdump];
        end
    end

endmodule

`default_nettype wire

// File: lfb_top.f
lfb_video_pkg.sv
lfb_mem_pkg.sv
lfb_line_ram.sv
lfb_hblank_timer.sv
lfb_ddr_ctrl.sv
lfb_scan_buf.sv
lfb_top.sv
lfb_mem_model.sv
tb_lfb_top.sv

// File: lfb_top.sv
`timescale 1ns/1ps
`default_nettype none

module lfb_top (
    input  logic                              clk,
    input  logic                              rst,
    // video timing
    input  logic                              pxl_cen,
    input  logic                              lhbl,
    input  logic                              frame,
    // renderer
    input  logic [lfb_video_pkg::HW-1:0]      ln_addr,
    input  logic [lfb_video_pkg::PXL_W-1:0]   ln_data,
    input  logic                              ln_we,
    input  logic                              ln_done,
    input  logic [lfb_video_pkg::VW-1:0]      vrender,
    input  logic [lfb_video_pkg::VW-1:0]      ln_v,
    output logic                              line,
    output logic                              fb_done,
    // video output
    input  logic [lfb_video_pkg::HW-1:0]      hdump,
    output logic [lfb_video_pkg::PXL_W-1:0]   pxl_data,
    // external memory
    input  logic                              mem_busy,
    output logic [7:0]                        mem_burstcnt,
    output logic [lfb_mem_pkg::MEM_AW-1:0]    mem_addr,
    input  logic [lfb_mem_pkg::MEM_DW-1:0]    mem_dout,
    input  logic                              mem_dout_ready,
    output logic                              mem_rd,
    output logic [lfb_mem_pkg::MEM_DW-1:0]    mem_din,
    output logic [7:0]                        mem_be,
    output logic                              mem_we,
    // status
    input  logic [7:0]                        st_addr,
    output logic [7:0]                        st_dout
);

    import lfb_video_pkg::*;

    logic [HW-1:0]    fb_addr;
    logic [PXL_W-1:0] fb_din;
    logic             fb_clr;
    logic [HW-1:0]    rd_addr;
    logic             scr_we;
    logic [HW-1:0]    hcnt;
    logic [HW-1:0]    hlim;
    logic             blank_start;
    logic             active;

    lfb_line_ram u_line_ram (
        .clk     (clk),
        .rst     (rst),
        .line    (line),
        .ln_addr (ln_addr),
        .ln_data (ln_data),
        .ln_we   (ln_we),
        .fb_addr (fb_addr),
        .fb_clr  (fb_clr),
        .fb_din  (fb_din)
    );

    lfb_hblank_timer u_hblank_timer (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .lhbl        (lhbl),
        .hcnt        (hcnt),
        .hlim        (hlim),
        .blank_start (blank_start),
        .active      (active)
    );

    lfb_ddr_ctrl u_ddr_ctrl (
        .clk            (clk),
        .rst            (rst),
        .ln_done        (ln_done),
        .vrender        (vrender),
        .ln_v           (ln_v),
        .frame          (frame),
        .fb_addr        (fb_addr),
        .fb_din         (fb_din),
        .fb_clr         (fb_clr),
        .fb_done        (fb_done),
        .line           (line),
        .rd_addr        (rd_addr),
        .scr_we         (scr_we),
        .hcnt           (hcnt),
        .hlim           (hlim),
        .blank_start    (blank_start),
        .active         (active),
        .mem_busy       (mem_busy),
        .mem_burstcnt   (mem_burstcnt),
        .mem_addr       (mem_addr),
        .mem_din        (mem_din),
        .mem_be         (mem_be),
        .mem_dout_ready (mem_dout_ready),
        .mem_rd         (mem_rd),
        .mem_we         (mem_we),
        .st_addr        (st_addr),
        .st_dout        (st_dout)
    );

    lfb_scan_buf u_scan_buf (
        .clk            (clk),
        .rst            (rst),
        .scr_we         (scr_we),
        .mem_dout_ready (mem_dout_ready),
        .rd_addr        (rd_addr),
        .wr_data        (mem_dout[PXL_W-1:0]),     // pixel in the low lane
        .hdump          (hdump),
        .pxl_data       (pxl_data)
    );

endmodule

`default_nettype wire

// File: lfb_video_pkg.sv
`default_nettype none

// video geometry shared by the line RAM, the controller and the screen buffer
package lfb_video_pkg;

    // vertical line index bits
    localparam int VW = 8;

    // column bits, one rendered line holds 512 pixels
    localparam int HW = 9;

    // pixel address inside the frame store: frame bit, line, column
    localparam int AW = HW + VW + 1;

    localparam int PXL_W = 16;          // one pixel, 16 bits

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the frame buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -j 0 -Wno-fatal --top-module tb_lfb_top \
    -f lfb_top.f -o tb_lfb_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_lfb_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" sim.log; then
    exit 0
fi
exit 1

// File: tb_lfb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lfb_top;

    import lfb_video_pkg::*;
    import lfb_mem_pkg::*;

    localparam logic [31:0] SEED     = 32'h4bc6_41d5;
    localparam int          TMO_DONE = 20000;       // cycles
    localparam int          TMO_LINE = 4000;

    logic              clk;
    logic              rst;
    logic              pxl_cen = 1'b0;
    logic              lhbl = 1'b0;
    logic              frame;
    logic [HW-1:0]     ln_addr;
    logic [PXL_W-1:0]  ln_data;
    logic              ln_we;
    logic              ln_done;
    logic [VW-1:0]     vrender;
    logic [VW-1:0]     ln_v;
    logic [HW-1:0]     hdump;
    logic [PXL_W-1:0]  pxl_data;
    logic              line;
    logic              fb_done;
    logic              mem_busy = 1'b0;
    logic [7:0]        mem_burstcnt;
    logic [MEM_AW-1:0] mem_addr;
    logic [MEM_DW-1:0] mem_dout;
    logic              mem_dout_ready;
    logic              mem_rd;
    logic [MEM_DW-1:0] mem_din;
    logic [7:0]        mem_be;
    logic              mem_we;
    logic [7:0]        st_addr;
    logic [7:0]        st_dout;

    logic [9:0]  hpos = '0;
    logic [9:0]  hpos_nx;
    logic        busy_on;
    logic [31:0] busy_state = ~SEED;
    logic [31:0] pix_state;
    logic        exp_line = 1'b0;
    int          errors = 0;
    int          timeouts = 0;
    int          line_cnt = 0;
    int          done_cnt = 0;
    int          rd_reqs = 0;
    int          beats = 0;
    logic [15:0] shadow [logic [17:0]];     // rendered pixels by frame, line, column

    lfb_top DUT (.*);

    lfb_mem_model u_mem (
        .clk            (clk),
        .rst            (rst),
        .mem_busy       (mem_busy),
        .mem_rd         (mem_rd),
        .mem_we         (mem_we),
        .mem_burstcnt   (mem_burstcnt),
        .mem_addr       (mem_addr),
        .mem_din        (mem_din),
        .mem_dout       (mem_dout),
        .mem_dout_ready (mem_dout_ready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // pixel the renderer drew there or zero from a cleared bank
    function automatic logic [PXL_W-1:0] expected_pixel(input logic frm,
            input logic [VW-1:0] v, input logic [HW-1:0] col);
        logic [17:0] key;
        key = {frm, v, col};
        if (shadow.exists(key)) begin
            return shadow[key];
        end
        return '0;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("end of run: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic fail_timeout(input string what);
        timeouts++;
        $display("timeout while waiting for %s", what);
        finish_run();
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // 640 pixel line with 512 shown and one pixel every second clock
    assign hpos_nx = (hpos == 10'd639) ? 10'd0 : hpos + 10'd1;

    always @(posedge clk) begin
        pxl_cen <= ~pxl_cen;
        if (pxl_cen) begin
            hpos <= hpos_nx;
            lhbl <= hpos_nx < 10'd512;
            if (hpos_nx == 10'd512) line_cnt <= line_cnt + 1;   // blank begins
        end
    end

    always @(posedge clk) begin
        busy_state <= lcg_next(busy_state);
        mem_busy   <= busy_on && busy_state[31:29] == 3'd0;    // about one in eight
    end

    // per-cycle checks on the memory port and the bank select
    always @(negedge clk) begin
        if (!rst) begin
            if (fb_done) begin
                exp_line = ~exp_line;
                done_cnt++;
            end
            check("line", 32'(line), 32'(exp_line));
            if (mem_we) check("mem_be", 32'(mem_be), 32'h03);   // low two byte lanes
            if (mem_rd && !mem_busy) begin
                rd_reqs++;
                check("mem_burstcnt", 32'(mem_burstcnt), 32'(BURST_LEN));
            end
            if (mem_dout_ready) beats++;
            check("mem_we during readback", 32'(mem_we & (mem_rd | (u_mem.rd_left != '0))), 0);
        end
    end

    task automatic wait_blank();
        int l0;
        int n;
        l0 = line_cnt;
        n  = 0;
        while (line_cnt == l0) begin
            @(posedge clk);
            n++;
            if (n > TMO_LINE) fail_timeout("horizontal blank");
        end
    endtask

    task automatic render_flush(input logic [VW-1:0] v, input logic frm, input logic sparse);
        logic              drawn;
        logic [MEM_AW-1:0] addr;
        int                d0;
        int                n;
        for (int c = 0; c < 512; c++) begin
            @(posedge clk);
            pix_state = lcg_next(pix_state);
            drawn     = !sparse || c[1:0] == 2'd0;
            frame   <= frm;
            ln_addr <= HW'(c);
            ln_data <= pix_state[31:16];
            ln_we   <= drawn;
            shadow[{frm, v, HW'(c)}] = drawn ? pix_state[31:16] : 16'h0000;
        end
        @(posedge clk);
        ln_we   <= 1'b0;
        vrender <= v;
        ln_done <= 1'b1;
        d0 = done_cnt;
        @(posedge clk);
        ln_done <= 1'b0;
        n = 0;
        while (done_cnt == d0) begin
            @(posedge clk);
            n++;
            if (n > TMO_DONE) fail_timeout("fb_done after ln_done");
        end
        for (int c = 0; c < 512; c++) begin
            addr = {MEM_BASE, {(MEM_AW - 4 - AW){1'b0}}, frm, v, HW'(c)};
            check("mem word", 32'(u_mem.read_word(addr)), 32'(expected_pixel(frm, v, HW'(c))));
        end
    endtask

    // shows line v of the frame opposite to frm
    task automatic readback_check(input logic [VW-1:0] v, input logic frm);
        int b0;
        int q0;
        int n;
        @(posedge clk);
        ln_v  <= v;
        frame <= frm;
        wait_blank();           // a read deferred by a flush may still run here
        wait_blank();
        b0 = beats;
        q0 = rd_reqs;
        n  = 0;
        while (beats - b0 < 512) begin
            @(posedge clk);
            n++;
            if (n > TMO_LINE) fail_timeout("readback beats");
        end
        check("read requests", 32'(rd_reqs - q0), 32'd4);
        @(posedge clk);
        hdump <= '0;
        for (int c = 1; c <= 512; c++) begin
            @(posedge clk);
            hdump <= HW'(c);    // pixel c-1 is registered on this edge
            @(negedge clk);
            check("pxl_data", 32'(pxl_data), 32'(expected_pixel(~frm, v, HW'(c - 1))));
        end
    endtask

    task automatic status_check(input logic frm);
        @(posedge clk);
        frame   <= frm;
        st_addr <= 8'h20;       // group 1
        repeat (3) @(posedge clk);
        @(negedge clk);
        check("st_dout frame", 32'(st_dout[4]), 32'(frm));
        check("st_dout line", 32'(st_dout[0]), 32'(exp_line));
        st_addr <= 8'h00;
    endtask

    initial begin
        rst       = 1'b1;
        frame     = 1'b0;
        ln_addr   = '0;
        ln_data   = '0;
        ln_we     = 1'b0;
        ln_done   = 1'b0;
        vrender   = '0;
        ln_v      = '0;
        hdump     = '0;
        st_addr   = '0;
        busy_on   = 1'b0;
        pix_state = SEED;
        repeat (10) begin
            @(negedge clk);
            check("mem_rd", 32'(mem_rd), 0);
            check("mem_we", 32'(mem_we), 0);
            check("fb_done", 32'(fb_done), 0);
            check("line", 32'(line), 0);
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("mem_rd", 32'(mem_rd), 0);
        check("mem_we", 32'(mem_we), 0);
        check("fb_done", 32'(fb_done), 0);
        check("line", 32'(line), 0);
        // full lines fill both banks and then a sparse line lands in a cleared bank
        render_flush(8'd5, 1'b0, 1'b0);
        render_flush(8'd6, 1'b0, 1'b0);
        render_flush(8'd7, 1'b0, 1'b1);
        readback_check(8'd7, 1'b1);
        readback_check(8'd5, 1'b1);
        status_check(1'b1);
        status_check(1'b0);
        @(posedge clk);
        busy_on <= 1'b1;
        render_flush(8'd9, 1'b1, 1'b0);
        render_flush(8'd10, 1'b1, 1'b1);
        readback_check(8'd9, 1'b0);
        readback_check(8'd10, 1'b0);
        readback_check(8'd7, 1'b1);
        finish_run();
    end

endmodule

`default_nettype wire
